//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = $clog2(XLEN);

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 for alu ops, shared by reg and imm forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
    struct packed {
      logic                  imm12;
      logic [5:0]            imm10_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm4_1;
      logic                  imm11;
      logic [6:0]            opcode;
    } b;
  } rv_inst_u;

endpackage

//--- rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // first fetch address after reset
  localparam logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0;

  // addi x0, x0, 0
  localparam logic [rv_isa_pkg::XLEN-1:0] NOP_INST = 32'h0000_0013;

  // ========================================
  // alu operation codes
  // ========================================
  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd9;
  // lui result is the immediate itself
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

endpackage

//--- rtl/rv_stage_ifs.sv
`timescale 1ns/10ps

// decode/execute pipeline register contents
interface rv_id_ex_if;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic                  valid;
  logic [XLEN-1:0]       pc;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rd;
  logic [ALU_OP_W-1:0]   alu_op;
  logic                  use_imm;
  logic                  reg_write;
  logic                  branch;
  logic                  branch_ne;

  modport decode_mp (
    output valid, pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd,
    output alu_op, use_imm, reg_write, branch, branch_ne
  );

  modport execute_mp (
    input valid, pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd,
    input alu_op, use_imm, reg_write, branch, branch_ne
  );
endinterface

// execute/write-back register, also the register file write port
interface rv_ex_wb_if;
  import rv_isa_pkg::*;

  logic                  valid;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       result;
  logic                  reg_write;

  modport execute_mp (output valid, rd, result, reg_write);
  modport writeback_mp (input valid, rd, result, reg_write);
endinterface

//--- rtl/rv_fetch_stage.sv
`timescale 1ns/10ps

module rv_fetch_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        redirect_i,
  input  logic [rv_isa_pkg::XLEN-1:0] redirect_pc_i,
  output logic [rv_isa_pkg::XLEN-1:0] pc_o,
  output logic                        fetch_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0] fetch_pc_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [XLEN-1:0] next_pc;

  // branch target wins over sequential fetch
  always_comb begin
    if (redirect_i) begin
      next_pc = redirect_pc_i;
    end else begin
      next_pc = pc_o + XLEN'(4);
    end
  end

  // the response arriving next cycle is dropped on redirect
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o          <= RESET_PC;
      fetch_valid_o <= 1'b0;
    end else begin
      pc_o          <= next_pc;
      fetch_valid_o <= ~redirect_i;
    end
  end

  // pc of the word now on inst_i
  always_ff @(posedge clk_i) begin
    fetch_pc_o <= pc_o;
  end

endmodule

//--- rtl/rv_reg_file.sv
`timescale 1ns/10ps

module rv_reg_file (
  input  logic                              clk_i,
  rv_ex_wb_if.writeback_mp                  wb,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data_o
);
  import rv_isa_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:(2**REG_ADDR_W)-1];
  logic            wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      regs[wb.rd] <= wb.result;
    end
  end

  // same-cycle write passes straight through
  always_comb begin
    rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
    if (wr_en && (wb.rd == rs1_addr_i)) begin
      rs1_data_o = wb.result;
    end
    if (wr_en && (wb.rd == rs2_addr_i)) begin
      rs2_data_o = wb.result;
    end
  end

endmodule

//--- rtl/rv_decode_stage.sv
`timescale 1ns/10ps

module rv_decode_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [rv_isa_pkg::XLEN-1:0] inst_i,
  input  logic                        fetch_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0] fetch_pc_i,
  input  logic                        flush_i,
  rv_id_ex_if.decode_mp               id_ex,
  rv_ex_wb_if.writeback_mp            wb
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  rv_inst_u            inst;
  logic                live;
  logic [XLEN-1:0]     imm_i_type;
  logic [XLEN-1:0]     imm_u_type;
  logic [XLEN-1:0]     imm_b_type;
  logic [XLEN-1:0]     rs1_data;
  logic [XLEN-1:0]     rs2_data;
  logic [XLEN-1:0]     imm;
  logic [ALU_OP_W-1:0] alu_op;
  logic                known;
  logic                use_imm;
  logic                reg_write;
  logic                branch;

  // dead slots decode as a nop
  assign live = fetch_valid_i && !flush_i;
  assign inst = live ? rv_inst_u'(inst_i) : rv_inst_u'(NOP_INST);

  // ========================================
  // immediates
  // ========================================
  assign imm_i_type = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
  assign imm_u_type = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
  assign imm_b_type = {{(XLEN-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};

  rv_reg_file u_reg_file (
    .clk_i      (clk_i),
    .wb         (wb),
    .rs1_addr_i (inst.r.rs1),
    .rs2_addr_i (inst.r.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // ========================================
  // control decode
  // ========================================
  always_comb begin
    known     = 1'b1;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    branch    = 1'b0;
    imm       = imm_i_type;
    case (inst.r.opcode)
      OPC_OP: begin
        reg_write = 1'b1;
        case (inst.r.funct3)
          F3_ADD_SUB: alu_op = (inst.r.funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL_SRA: alu_op = (inst.r.funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          default:    alu_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        case (inst.i.funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          // shifts and sltiu not supported
          default:    known = 1'b0;
        endcase
      end
      OPC_LUI: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        alu_op    = ALU_PASS_B;
        imm       = imm_u_type;
      end
      OPC_BRANCH: begin
        branch = 1'b1;
        imm    = imm_b_type;
        known  = (inst.b.funct3 == F3_BEQ) || (inst.b.funct3 == F3_BNE);
      end
      default: known = 1'b0;
    endcase
  end

  // ========================================
  // decode/execute register
  // ========================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex.valid     <= 1'b0;
      id_ex.reg_write <= 1'b0;
      id_ex.branch    <= 1'b0;
    end else begin
      id_ex.valid     <= live && known;
      id_ex.reg_write <= live && known && reg_write && (inst.r.rd != '0);
      id_ex.branch    <= live && known && branch;
    end
  end

  always_ff @(posedge clk_i) begin
    id_ex.pc        <= fetch_pc_i;
    id_ex.rs1_addr  <= inst.r.rs1;
    id_ex.rs2_addr  <= inst.r.rs2;
    id_ex.rs1_data  <= rs1_data;
    id_ex.rs2_data  <= rs2_data;
    id_ex.imm       <= imm;
    id_ex.rd        <= inst.r.rd;
    id_ex.alu_op    <= alu_op;
    id_ex.use_imm   <= use_imm;
    id_ex.branch_ne <= (inst.b.funct3 == F3_BNE);
  end

endmodule

//--- rtl/rv_execute_stage.sv
`timescale 1ns/10ps

module rv_execute_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  rv_id_ex_if.execute_mp              id_ex,
  rv_ex_wb_if.execute_mp              ex_wb,
  output logic                        redirect_o,
  output logic [rv_isa_pkg::XLEN-1:0] redirect_pc_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_rs2;
  logic [XLEN-1:0]    op_b;
  logic [XLEN-1:0]    alu_result;
  logic [SHAMT_W-1:0] shamt;
  logic               wb_hit_rs1;
  logic               wb_hit_rs2;
  logic               operands_eq;

  // ========================================
  // forwarding from write-back
  // ========================================
  assign wb_hit_rs1 = ex_wb.valid && ex_wb.reg_write && (ex_wb.rd == id_ex.rs1_addr);
  assign wb_hit_rs2 = ex_wb.valid && ex_wb.reg_write && (ex_wb.rd == id_ex.rs2_addr);

  assign op_a   = wb_hit_rs1 ? ex_wb.result : id_ex.rs1_data;
  assign op_rs2 = wb_hit_rs2 ? ex_wb.result : id_ex.rs2_data;
  assign op_b   = id_ex.use_imm ? id_ex.imm : op_rs2;
  assign shamt  = op_b[SHAMT_W-1:0];

  // alu
  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // branch resolution, beq or bne
  assign operands_eq   = (op_a == op_rs2);
  assign redirect_o    = id_ex.valid && id_ex.branch && (operands_eq ^ id_ex.branch_ne);
  assign redirect_pc_o = id_ex.pc + id_ex.imm;

  // ========================================
  // execute/write-back register
  // ========================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_wb.valid     <= 1'b0;
      ex_wb.reg_write <= 1'b0;
    end else begin
      ex_wb.valid     <= id_ex.valid;
      ex_wb.reg_write <= id_ex.valid && id_ex.reg_write;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_wb.rd     <= id_ex.rd;
    ex_wb.result <= alu_result;
  end

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  output logic [rv_isa_pkg::XLEN-1:0]       pc_o,
  input  logic [rv_isa_pkg::XLEN-1:0]       inst_i,
  output logic                              wb_valid_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]       wb_data_o
);
  import rv_isa_pkg::*;

  logic            fetch_valid;
  logic [XLEN-1:0] fetch_pc;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;

  rv_id_ex_if id_ex ();
  rv_ex_wb_if ex_wb ();

  rv_fetch_stage u_fetch (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .pc_o          (pc_o),
    .fetch_valid_o (fetch_valid),
    .fetch_pc_o    (fetch_pc)
  );

  // a taken branch also kills the word in decode
  rv_decode_stage u_decode (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .inst_i        (inst_i),
    .fetch_valid_i (fetch_valid),
    .fetch_pc_i    (fetch_pc),
    .flush_i       (redirect),
    .id_ex         (id_ex),
    .wb            (ex_wb)
  );

  rv_execute_stage u_execute (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .id_ex         (id_ex),
    .ex_wb         (ex_wb),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  // retire port reports register writes only
  assign wb_valid_o = ex_wb.valid && ex_wb.reg_write;
  assign wb_rd_o    = ex_wb.rd;
  assign wb_data_o  = ex_wb.result;

endmodule

//--- verif/rv_core_properties.sv
`timescale 1ns/10ps

module rv_core_properties (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic [rv_isa_pkg::XLEN-1:0]       pc_o,
  input logic                              wb_valid_o,
  input logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_o
);

  // read by the testbench for its closing count
  int assert_failures = 0;

  // fetch only ever steps by words
  pc_aligned: assert property (@(posedge clk_i) pc_o[1:0] == 2'b00)
    else begin
      $error("pc_o is not word aligned: 0x%h", pc_o);
      assert_failures++;
    end

  // writes to x0 are dropped in decode
  no_x0_retire: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_o |-> (wb_rd_o != '0))
    else begin
      $error("retire reported for register x0");
      assert_failures++;
    end

  quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_valid_o)
    else begin
      $error("wb_valid_o high while reset is asserted");
      assert_failures++;
    end

endmodule

bind rv_core_top rv_core_properties i_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .pc_o       (pc_o),
  .wb_valid_o (wb_valid_o),
  .wb_rd_o    (wb_rd_o)
);

//--- verif/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int    RESET_CYCLES   = 16;
  localparam int    RETIRE_TIMEOUT = 50;
  localparam int    DRAIN_CYCLES   = 24;
  localparam string STIM_FILE      = "verif/rv_core_stimulus.txt";

  logic                  clk_i;
  logic                  rst_n_i;
  logic [XLEN-1:0]       pc_o;
  logic [XLEN-1:0]       inst_i;
  logic                  wb_valid_o;
  logic [REG_ADDR_W-1:0] wb_rd_o;
  logic [XLEN-1:0]       wb_data_o;

  logic [XLEN-1:0]       prog [$];
  logic [REG_ADDR_W-1:0] exp_rd [$];
  logic [XLEN-1:0]       exp_data [$];
  logic [XLEN-1:0]       reset_junk [RESET_CYCLES];
  logic [3:0]            junk_idx;
  int                    errors;
  int                    checks;

  rv_core_top i_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pc_o       (pc_o),
    .inst_i     (inst_i),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ========================================
  // instruction memory, one cycle latency
  // ========================================
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      // garbage while in reset, fetch_valid keeps it out
      inst_i   <= reset_junk[junk_idx];
      junk_idx <= junk_idx + 4'd1;
    end else if (int'(pc_o[XLEN-1:2]) < prog.size()) begin
      inst_i <= prog[pc_o[XLEN-1:2]];
    end else begin
      inst_i <= NOP_INST;
    end
  end

  task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] actual,
                          input logic [REG_ADDR_W-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] actual,
                            input logic [XLEN-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic load_stimulus();
    int                    fd;
    int                    n;
    int                    branches;
    string                 line;
    logic [XLEN-1:0]       word;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    rv_inst_u              inst;
    branches = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        if ($sscanf(line, "I %h", word) == 1) begin
          inst = rv_inst_u'(word);
          if (inst.b.opcode == OPC_BRANCH) begin
            branches++;
          end
          prog.push_back(word);
        end else if ($sscanf(line, "E %h %h", rd, data) == 2) begin
          exp_rd.push_back(rd);
          exp_data.push_back(data);
        end
      end
    end
    $fclose(fd);
    $display("loaded %0d words, %0d branches, %0d retires expected",
             prog.size(), branches, exp_rd.size());
  endtask

  // one retire per call, sampled at the falling edge
  task automatic wait_retire(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < RETIRE_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      if (wb_valid_o === 1'b1) begin
        seen = 1'b1;
      end
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    bit seen;
    bit timed_out;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    rst_n_i   = 1'b0;
    inst_i    = NOP_INST;
    junk_idx  = '0;
    void'($urandom(32'h58dd));
    foreach (reset_junk[k]) begin
      reset_junk[k] = $urandom();
    end
    load_stimulus();
    if (exp_rd.size() == 0) begin
      errors++;
      $display("stimulus holds no expected retires");
    end

    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk_i);
      if (wb_valid_o !== 1'b0) begin
        errors++;
        $display("a retire was reported while reset was asserted");
      end
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_data("pc_o", pc_o, RESET_PC);

    // retires must follow program order exactly
    for (int n = 0; n < exp_rd.size() && !timed_out; n++) begin
      wait_retire(seen);
      if (!seen) begin
        errors++;
        timed_out = 1'b1;
        $display("timed out waiting for retire number %0d", n);
      end else begin
        check_rd("wb_rd_o", wb_rd_o, exp_rd[n]);
        check_data("wb_data_o", wb_data_o, exp_data[n]);
      end
    end

    // flushed slots and x0 writes stay silent
    for (int c = 0; c < DRAIN_CYCLES; c++) begin
      @(negedge clk_i);
      if (wb_valid_o !== 1'b0) begin
        errors++;
        $display("unexpected retire to x%0d with value 0x%h", wb_rd_o, wb_data_o);
      end
    end

    errors += i_dut.i_props.assert_failures;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verif/rv_core_stimulus.txt
# I <instruction word hex> : program words from address 0, in order
# E <rd hex> <result hex>  : expected retires, in retire order
I 800000B7  lui  x1, 0x80000
I FF900113  addi x2, x0, -7
I 00C10193  addi x3, x2, 12
I 00308233  add  x4, x1, x3
I 404182B3  sub  x5, x3, x4
I 00417333  and  x6, x2, x4
I 0032E3B3  or   x7, x5, x3
I 0023C433  xor  x8, x7, x2
I 0030A4B3  slt  x9, x1, x3
I 0030B533  sltu x10, x1, x3
I 003195B3  sll  x11, x3, x3
I 0030D633  srl  x12, x1, x3
I 4030D6B3  sra  x13, x1, x3
I FFA12713  slti x14, x2, -6
I 0F01C793  xori x15, x3, 0xf0
I F007E813  ori  x16, x15, -256
I 07F87893  andi x17, x16, 0x7f
I 00118013  addi x0, x3, 1
I 00300933  add  x18, x0, x3
I 01218663  beq  x3, x18, +12 taken
I 00100A13  addi x20, x0, 1 skipped
I 00100A93  addi x21, x0, 1 skipped
I 01219463  bne  x3, x18, +8 not taken
I 02200B13  addi x22, x0, 0x22
I 000B1663  bne  x22, x0, +12 taken
I 00200A13  addi x20, x0, 2 skipped
I 00200A93  addi x21, x0, 2 skipped
I FE018CE3  beq  x3, x0, -8 not taken
I FFFB0B93  addi x23, x22, -1
E 01 80000000
E 02 FFFFFFF9
E 03 00000005
E 04 80000005
E 05 80000000
E 06 80000001
E 07 80000005
E 08 7FFFFFFC
E 09 00000001
E 0A 00000000
E 0B 000000A0
E 0C 04000000
E 0D FC000000
E 0E 00000001
E 0F 000000F5
E 10 FFFFFFF5
E 11 00000075
E 12 00000005
E 16 00000022
E 17 00000021

//--- rv_core_top.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_stage_ifs.sv
rtl/rv_fetch_stage.sv
rtl/rv_reg_file.sv
rtl/rv_decode_stage.sv
rtl/rv_execute_stage.sv
rtl/rv_core_top.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
